/* Bender.yml */
package:
  name: emesh_mem

sources:
  - logic/emesh_pkg.sv
  - logic/emesh_decode.sv
  - logic/packet_fifo.sv
  - logic/mem_engine.sv
  - logic/emesh_mem.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/emesh_mem_tb.sv

/* emesh_mem.f */
+incdir+verif
logic/emesh_pkg.sv
logic/emesh_decode.sv
logic/packet_fifo.sv
logic/mem_engine.sv
logic/emesh_mem.sv
verif/emesh_mem_tb.sv

/* logic/emesh_decode.sv */
`timescale 1ns/100ps

module emesh_decode (
   input  logic                   clk,
   input  logic                   rst_n,
   // Incoming mesh traffic
   input  logic                   access_in,
   input  emesh_pkg::emesh_packet_t packet_in,
   output logic                   wait_out,
   // Write command queue
   output logic                   wr_valid,
   input  logic                   wr_ready,
   output emesh_pkg::wr_cmd_t     wr_item,
   // Read command queue
   output logic                   rd_valid,
   input  logic                   rd_ready,
   output emesh_pkg::rd_cmd_t     rd_item
);

   logic                     stage_valid;        // Stage holds a packet
   emesh_pkg::emesh_packet_t stage_pkt;          // Staged packet
   logic                     target_ready;       // Queue picked by write bit
   logic                     drain;              // Stage empties this edge
   logic                     accept;             // Handshake on access_in
   logic [emesh_pkg::MEM_AW-1:0] word_idx;       // dstaddr[9:2]

   // ##############################
   // Handshake
   // ##############################
   assign target_ready = stage_pkt.write ? wr_ready : rd_ready;
   assign drain        = stage_valid & target_ready;
   assign wait_out     = stage_valid & ~target_ready; // Full and blocked
   assign accept       = access_in & ~wait_out;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         stage_valid <= 1'b0;
      end else if (accept) begin
         stage_valid <= 1'b1;                    // Refill, maybe while draining
      end else if (drain) begin
         stage_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         stage_pkt <= packet_in;                 // Kind rides in the write bit
      end
   end

   // ##############################
   // Command build
   // ##############################
   assign word_idx = stage_pkt.dstaddr[emesh_pkg::MEM_AW+1:2]; // Byte to word

   assign wr_valid         = stage_valid & stage_pkt.write;
   assign wr_item.addr     = word_idx;
   assign wr_item.data     = stage_pkt.data;
   assign wr_item.ctrlmode = stage_pkt.ctrlmode;
   assign wr_item.datamode = stage_pkt.datamode;

   assign rd_valid         = stage_valid & ~stage_pkt.write;
   assign rd_item.addr     = word_idx;
   assign rd_item.retaddr  = stage_pkt.srcaddr;  // Response goes back here
   assign rd_item.ctrlmode = stage_pkt.ctrlmode;
   assign rd_item.datamode = stage_pkt.datamode;

endmodule

/* logic/emesh_mem.sv */
`timescale 1ns/100ps

module emesh_mem (
   input  logic                     clk,
   input  logic                     rst_n,
   // Requests from the mesh
   input  logic                     access_in,
   input  logic [emesh_pkg::PW-1:0] packet_in,
   output logic                     wait_out,
   // Read responses to the mesh
   output logic                     access_out,
   output logic [emesh_pkg::PW-1:0] packet_out,
   input  logic                     wait_in
);

   emesh_pkg::emesh_packet_t pkt_in;             // Typed view of packet_in
   emesh_pkg::emesh_packet_t pkt_out;            // Typed response

   // Decoder to queues
   logic                 wq_push_valid;
   logic                 wq_push_ready;
   emesh_pkg::wr_cmd_t   wq_push_item;
   logic                 rq_push_valid;
   logic                 rq_push_ready;
   emesh_pkg::rd_cmd_t   rq_push_item;

   // Queues to engine
   logic                 wq_pop_valid;
   logic                 wq_pop_ready;
   emesh_pkg::wr_cmd_t   wq_pop_item;
   logic                 rq_pop_valid;
   logic                 rq_pop_ready;
   emesh_pkg::rd_cmd_t   rq_pop_item;

   // ##############################
   // Flat ports to structs
   // ##############################
   assign pkt_in     = packet_in;
   assign packet_out = pkt_out;

   // ##############################
   // Blocks
   // ##############################
   emesh_decode decode0 (
      .clk       (clk),
      .rst_n     (rst_n),
      .access_in (access_in),
      .packet_in (pkt_in),
      .wait_out  (wait_out),
      .wr_valid  (wq_push_valid),
      .wr_ready  (wq_push_ready),
      .wr_item   (wq_push_item),
      .rd_valid  (rq_push_valid),
      .rd_ready  (rq_push_ready),
      .rd_item   (rq_push_item)
   );

   packet_fifo #(.item_t(emesh_pkg::wr_cmd_t)) wr_fifo0 ( // Write commands
      .clk        (clk),
      .rst_n      (rst_n),
      .push_valid (wq_push_valid),
      .push_ready (wq_push_ready),
      .push_item  (wq_push_item),
      .pop_valid  (wq_pop_valid),
      .pop_ready  (wq_pop_ready),
      .pop_item   (wq_pop_item)
   );

   packet_fifo #(.item_t(emesh_pkg::rd_cmd_t)) rd_fifo0 ( // Read commands
      .clk        (clk),
      .rst_n      (rst_n),
      .push_valid (rq_push_valid),
      .push_ready (rq_push_ready),
      .push_item  (rq_push_item),
      .pop_valid  (rq_pop_valid),
      .pop_ready  (rq_pop_ready),
      .pop_item   (rq_pop_item)
   );

   mem_engine engine0 (
      .clk        (clk),
      .rst_n      (rst_n),
      .wr_valid   (wq_pop_valid),
      .wr_ready   (wq_pop_ready),
      .wr_item    (wq_pop_item),
      .rd_valid   (rq_pop_valid),
      .rd_ready   (rq_pop_ready),
      .rd_item    (rq_pop_item),
      .access_out (access_out),
      .packet_out (pkt_out),
      .wait_in    (wait_in)                      // Stalls reads only
   );

endmodule

/* logic/emesh_pkg.sv */
package emesh_pkg;

   // ##############################
   // Packet geometry
   // ##############################
   localparam int PW      = 104;                 // Full mesh packet
   localparam int AW      = 32;                  // Address fields
   localparam int DW      = 32;                  // Data field
   localparam int CTRL_W  = 5;                   // Ctrlmode field
   localparam int DMODE_W = 2;                   // Datamode field

   // ##############################
   // Storage sizes
   // ##############################
   localparam int MEM_DEPTH  = 256;              // Words in the array
   localparam int MEM_AW     = 8;                // Word index bits
   localparam int FIFO_DEPTH = 4;                // Entries per command queue
   localparam int FIFO_AW    = $clog2(FIFO_DEPTH);     // Queue pointer bits
   localparam int FIFO_CW    = $clog2(FIFO_DEPTH + 1); // Queue count bits

   // ##############################
   // Packed structs
   // ##############################

   // Mesh packet, msb first; dstaddr lands on bits 39:8
   typedef struct packed {
      logic [AW-1:0]      srcaddr;               // Return address on reads
      logic [DW-1:0]      data;                  // Write data / read data
      logic [AW-1:0]      dstaddr;               // Target byte address
      logic [CTRL_W-1:0]  ctrlmode;              // Passed through untouched
      logic [DMODE_W-1:0] datamode;              // Size code, word only here
      logic               write;                 // 1 = write, 0 = read
   } emesh_packet_t;

   // Queued write, decoded down to a word index
   typedef struct packed {
      logic [MEM_AW-1:0]  addr;                  // Word index
      logic [DW-1:0]      data;                  // Word to store
      logic [CTRL_W-1:0]  ctrlmode;              // Carried along
      logic [DMODE_W-1:0] datamode;              // Carried along
   } wr_cmd_t;

   // Queued read, keeps what the response needs
   typedef struct packed {
      logic [MEM_AW-1:0]  addr;                  // Word index
      logic [AW-1:0]      retaddr;               // Request srcaddr
      logic [CTRL_W-1:0]  ctrlmode;              // Echoed in response
      logic [DMODE_W-1:0] datamode;              // Echoed in response
   } rd_cmd_t;

endpackage

/* logic/mem_engine.sv */
`timescale 1ns/100ps

module mem_engine (
   input  logic                     clk,
   input  logic                     rst_n,
   // Write command queue
   input  logic                     wr_valid,
   output logic                     wr_ready,
   input  emesh_pkg::wr_cmd_t       wr_item,
   // Read command queue
   input  logic                     rd_valid,
   output logic                     rd_ready,
   input  emesh_pkg::rd_cmd_t       rd_item,
   // Outgoing read responses
   output logic                     access_out,
   output emesh_pkg::emesh_packet_t packet_out,
   input  logic                     wait_in
);

   logic [emesh_pkg::DW-1:0] mem [emesh_pkg::MEM_DEPTH]; // Word array

   logic                     wr_fire;            // Write served this edge
   logic                     rd_fire;            // Read served this edge
   logic                     resp_valid;         // Response register full
   logic                     resp_free;          // Empty or leaving now
   emesh_pkg::emesh_packet_t resp_pkt;           // Response register
   emesh_pkg::emesh_packet_t resp_next;          // Response being built
   logic [emesh_pkg::DW-1:0] rd_word;            // Array read data

   // ##############################
   // Write-first arbitration
   // ##############################

   // Writes never stall, one memory cycle each
   assign wr_ready = 1'b1;
   assign wr_fire  = wr_valid & wr_ready;

   // Response slot frees up when empty or taken downstream
   assign resp_free = ~resp_valid | ~wait_in;

   // Read loses to any waiting write
   assign rd_ready = ~wr_valid & resp_free;
   assign rd_fire  = rd_valid & rd_ready;

   // ##############################
   // Memory array
   // ##############################
   always_ff @(posedge clk) begin
      if (wr_fire) begin
         mem[wr_item.addr] <= wr_item.data;      // Full word, datamode ignored
      end
   end

   // Asynchronous read; no write can land in the same cycle
   assign rd_word = mem[rd_item.addr];

   // ##############################
   // Response build
   // ##############################
   always_comb begin
      resp_next          = '0;                   // srcaddr stays zero
      resp_next.write    = 1'b1;                 // Read response goes out as write
      resp_next.dstaddr  = rd_item.retaddr;      // Back to the requester
      resp_next.data     = rd_word;
      resp_next.ctrlmode = rd_item.ctrlmode;     // Echo request modes
      resp_next.datamode = rd_item.datamode;
   end

   // ##############################
   // Response register
   // ##############################
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         resp_valid <= 1'b0;
      end else if (rd_fire) begin
         resp_valid <= 1'b1;                     // New response, old one gone
      end else if (~wait_in) begin
         resp_valid <= 1'b0;                     // Taken by receiver
      end
   end

   // Held stable while wait_in is high
   always_ff @(posedge clk) begin
      if (rd_fire) begin
         resp_pkt <= resp_next;
      end
   end

   assign access_out = resp_valid;
   assign packet_out = resp_pkt;

endmodule

/* logic/packet_fifo.sv */
`timescale 1ns/100ps

module packet_fifo #(
   parameter type item_t = logic [7:0]           // Queued payload
) (
   input  logic  clk,
   input  logic  rst_n,
   // Producer side
   input  logic  push_valid,
   output logic  push_ready,
   input  item_t push_item,
   // Consumer side
   output logic  pop_valid,
   input  logic  pop_ready,
   output item_t pop_item
);

   item_t entries [emesh_pkg::FIFO_DEPTH];       // Circular storage

   logic [emesh_pkg::FIFO_AW-1:0] wr_ptr;        // Next free slot
   logic [emesh_pkg::FIFO_AW-1:0] rd_ptr;        // Head slot
   logic [emesh_pkg::FIFO_CW-1:0] count;         // Occupancy
   logic                          push_fire;
   logic                          pop_fire;

   // Pointer step with wrap, depth need not be a power of two
   function automatic logic [emesh_pkg::FIFO_AW-1:0] next_ptr(
      input logic [emesh_pkg::FIFO_AW-1:0] ptr
   );
      if (ptr == emesh_pkg::FIFO_AW'(emesh_pkg::FIFO_DEPTH - 1)) begin
         return '0;
      end
      return ptr + emesh_pkg::FIFO_AW'(1);
   endfunction

   // ##############################
   // Status and show-ahead head
   // ##############################
   assign push_ready = (count != emesh_pkg::FIFO_CW'(emesh_pkg::FIFO_DEPTH)); // Not full
   assign pop_valid  = (count != '0);            // Something at the head
   assign pop_item   = entries[rd_ptr];          // Head shown ahead

   assign push_fire = push_valid & push_ready;
   assign pop_fire  = pop_valid & pop_ready;

   // ##############################
   // Pointers and count
   // ##############################
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push_fire) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (pop_fire) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         case ({push_fire, pop_fire})
            2'b10:   count <= count + emesh_pkg::FIFO_CW'(1); // Push only
            2'b01:   count <= count - emesh_pkg::FIFO_CW'(1); // Pop only
            default: count <= count;             // Idle or both
         endcase
      end
   end

   // Payload storage
   always_ff @(posedge clk) begin
      if (push_fire) begin
         entries[wr_ptr] <= push_item;
      end
   end

endmodule

/* verif/emesh_mem_tests.svh */
`ifndef EMESH_MEM_TESTS_SVH
`define EMESH_MEM_TESTS_SVH

// ##############################
// Idle outputs after reset
// ##############################
task automatic test_reset_state();
   int i;
   begin_test("reset_state");
   for (i = 0; i < 10; i++) begin
      @(negedge clk);
      check_value("access_out", 1'b0, access_out);
      check_value("wait_out", 1'b0, wait_out);
   end
   @(posedge clk);
   #DRIVE_DLY;
   end_test();
endtask

// One word out and back, fields checked one by one
task automatic test_write_read();
   emesh_pkg::emesh_packet_t got;
   begin_test("write_read");
   send_pkt(make_pkt(32'h0, 32'hC0FF_EE42, 32'h0000_0120, 5'h03, 2'b10, 1'b1));
   send_pkt(make_pkt(32'h8000_1234, 32'h0, 32'h0000_0120, 5'h15, 2'b01, 1'b0));
   recv_check(got);
   check_value("write bit", 1'b1, got.write);
   check_value("dstaddr", 32'h8000_1234, got.dstaddr);
   check_value("data", 32'hC0FF_EE42, got.data);
   check_value("srcaddr", 32'h0, got.srcaddr);
   check_value("ctrlmode", 5'h15, got.ctrlmode);
   check_value("datamode", 2'b01, got.datamode);
   end_test();
endtask

task automatic test_lcg_burst();
   emesh_pkg::emesh_packet_t got;
   logic [31:0]              addrs [16];
   logic [31:0]              r;
   int                       i;
   begin_test("lcg_burst");
   for (i = 0; i < 16; i++) begin
      addrs[i] = lcg_next() & 32'hFFFF_FFFC;     // Word aligned, high bits alias
      send_pkt(make_pkt(32'h0, lcg_next(), addrs[i], 5'h0, 2'b10, 1'b1));
   end
   for (i = 0; i < 16; i++) begin
      r = lcg_next();
      send_pkt(make_pkt(lcg_next(), 32'h0, addrs[i], r[4:0], r[6:5], 1'b0));
   end
   for (i = 0; i < 16; i++) begin
      recv_check(got);                           // Request order
   end
   end_test();
endtask

// ##############################
// Stalled receiver
// ##############################
task automatic test_backpressure();
   emesh_pkg::emesh_packet_t pkt;
   emesh_pkg::emesh_packet_t got;
   int                       i;
   int                       issued;
   logic                     rose;
   begin_test("backpressure");
   for (i = 0; i < 8; i++) begin
      send_pkt(make_pkt(32'h0, lcg_next(), 32'h200 + 32'(i * 4), 5'h0, 2'b10, 1'b1));
   end
   wait_in = 1'b1;
   issued  = 0;
   rose    = 1'b0;
   while (!rose && issued < emesh_pkg::FIFO_DEPTH + 8) begin
      pkt = make_pkt(32'hB000_0000 + 32'(issued), 32'h0, 32'h200 + 32'((issued % 8) * 4),
                     5'h0A, 2'b10, 1'b0);
      access_in = 1'b1;
      packet_in = pkt;
      @(negedge clk);
      if (wait_out) begin
         rose = 1'b1;                            // Held until wait_out drops
      end else begin
         @(posedge clk);
         #DRIVE_DLY;
         note_sent(pkt);
         issued++;
      end
   end
   if (!rose) begin
      access_in = 1'b0;                          // Last one already taken
   end
   check_true(rose, "wait_out never rose while wait_in was held high");
   check_true(issued + 1 <= emesh_pkg::FIFO_DEPTH + 3,
              $sformatf("wait_out rose only after %0d reads", issued + 1));
   if (exp_q.size() != 0) begin
      check_value("held access_out", 1'b1, access_out); // Oldest answer parked
      check_value("held response", exp_q[0], packet_out);
   end
   @(posedge clk);
   #DRIVE_DLY;
   wait_in = 1'b0;
   if (rose) begin
      send_pkt(pkt);                             // Same packet, access never dropped
      issued++;
   end
   for (i = 0; i < issued; i++) begin
      recv_check(got);
   end
   end_test();
endtask

// Two passes so the second read must see the newer word
task automatic test_interleaved();
   emesh_pkg::emesh_packet_t got;
   logic [31:0]              addr;
   int                       pass;
   int                       i;
   begin_test("interleaved");
   for (pass = 0; pass < 2; pass++) begin
      for (i = 0; i < 8; i++) begin
         addr = 32'h300 + 32'(i * 8);            // Distinct word per pair
         send_pkt(make_pkt(32'h0, lcg_next(), addr, 5'h0, 2'b10, 1'b1));
         send_pkt(make_pkt(32'hD000_0000 | 32'(i), 32'h0, addr, 5'(i), 2'b10, 1'b0));
      end
      for (i = 0; i < 8; i++) begin
         recv_check(got);
      end
   end
   end_test();
endtask

task automatic test_aliasing();
   emesh_pkg::emesh_packet_t got;
   logic [31:0]              low;
   begin_test("aliasing");
   low = 32'(8'h5A) << 2;
   send_pkt(make_pkt(32'h0, 32'hA11A_5ED0, 32'h1234_5400 | low, 5'h0, 2'b10, 1'b1));
   send_pkt(make_pkt(32'hE000_0001, 32'h0, low, 5'h1, 2'b10, 1'b0));
   send_pkt(make_pkt(32'hE000_0002, 32'h0, 32'hFFFF_FC00 | low, 5'h2, 2'b10, 1'b0));
   recv_check(got);
   check_value("low alias data", 32'hA11A_5ED0, got.data);
   recv_check(got);
   check_value("high alias data", 32'hA11A_5ED0, got.data);
   end_test();
endtask

`endif

/* verif/emesh_mem_tb.sv */
`timescale 1ns/100ps

module emesh_mem_tb;

   localparam int          CLK_HALF       = 4;   // 8 ns period
   localparam int          DRIVE_DLY      = 1;   // Input skew after posedge
   localparam int          RST_CYCLES     = 8;
   localparam int          TIMEOUT_CYCLES = 200; // Per wait loop
   localparam logic [31:0] LCG_SEED       = 32'd31033;

   logic                     clk;
   logic                     rst_n;
   logic                     access_in;
   logic [emesh_pkg::PW-1:0] packet_in;
   logic                     wait_out;
   logic                     access_out;
   logic [emesh_pkg::PW-1:0] packet_out;
   logic                     wait_in;

   logic [31:0]              ref_mem [emesh_pkg::MEM_DEPTH]; // Memory model
   emesh_pkg::emesh_packet_t exp_q [$];          // Responses still owed
   emesh_pkg::emesh_packet_t resp_q [$];         // Responses taken from DUT
   logic [31:0]              lcg_state;
   string                    test_name;
   int                       tests_run;
   int                       tests_failed;
   int                       checks;
   int                       errors;
   int                       test_errors;

   emesh_mem dut0 (
      .clk        (clk),
      .rst_n      (rst_n),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_out   (wait_out),
      .access_out (access_out),
      .packet_out (packet_out),
      .wait_in    (wait_in)
   );

   always #CLK_HALF clk = ~clk;

   // Sampled mid-cycle, the transfer itself is on the next rising edge
   always @(negedge clk) begin
      if (rst_n && access_out && !wait_in) begin
         resp_q.push_back(packet_out);
      end
   end

   // ##############################
   // Models and helpers
   // ##############################
   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic [7:0] word_index(input logic [31:0] addr);
      return addr[9:2];                          // Byte address to word
   endfunction

   function automatic emesh_pkg::emesh_packet_t make_pkt(
      input logic [31:0] src, data, dst,
      input logic [4:0]  ctrl,
      input logic [1:0]  dmode,
      input logic        wr
   );
      emesh_pkg::emesh_packet_t p;
      p.srcaddr  = src;
      p.data     = data;
      p.dstaddr  = dst;
      p.ctrlmode = ctrl;
      p.datamode = dmode;
      p.write    = wr;
      return p;
   endfunction

   // Read answer goes back as a write aimed at the requester
   function automatic emesh_pkg::emesh_packet_t resp_expected(
      input emesh_pkg::emesh_packet_t req
   );
      return make_pkt(32'h0, ref_mem[word_index(req.dstaddr)], req.srcaddr,
                      req.ctrlmode, req.datamode, 1'b1);
   endfunction

   task automatic fail_run(input string reason);
      $display("%s: %s", test_name, reason);
      $display("Test FAILED");
      $finish;
   endtask

   task automatic check_value(input string what, input logic [103:0] exp,
                              input logic [103:0] act);
      checks++;
      assert (act === exp) else begin
         $display("[ERROR] %s %s: expected %0h, actual %0h", test_name, what, exp, act);
         errors++;
         test_errors++;
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      checks++;
      assert (cond) else begin
         $display("%s: %s", test_name, what);
         errors++;
         test_errors++;
      end
   endtask

   // Model update once the DUT has taken the packet
   task automatic note_sent(input emesh_pkg::emesh_packet_t pkt);
      if (pkt.write) begin
         ref_mem[word_index(pkt.dstaddr)] = pkt.data;
      end else begin
         exp_q.push_back(resp_expected(pkt));
      end
   endtask

   // Called at posedge plus skew, returns at the same phase
   task automatic send_pkt(input emesh_pkg::emesh_packet_t pkt);
      int   waited;
      logic done;
      waited    = 0;
      done      = 1'b0;
      access_in = 1'b1;
      packet_in = pkt;
      while (!done && waited < TIMEOUT_CYCLES) begin
         @(negedge clk);
         done = !wait_out;                       // Accepted on next edge
         @(posedge clk);
         #DRIVE_DLY;
         waited++;
      end
      access_in = 1'b0;
      if (!done) begin
         fail_run("packet not accepted, wait_out stayed high");
      end else begin
         note_sent(pkt);
      end
   endtask

   task automatic recv_check(output emesh_pkg::emesh_packet_t got);
      int waited;
      waited = 0;
      while (resp_q.size() == 0 && waited < TIMEOUT_CYCLES) begin
         @(posedge clk);
         #DRIVE_DLY;
         waited++;
      end
      if (resp_q.size() == 0) begin
         fail_run("no read response on access_out before timeout");
      end else begin
         got = resp_q.pop_front();
         check_true(exp_q.size() != 0, "response arrived with no read outstanding");
         if (exp_q.size() != 0) begin
            check_value("response", exp_q.pop_front(), got);
         end
      end
   endtask

   task automatic begin_test(input string name);
      test_name   = name;
      test_errors = 0;
      tests_run++;
   endtask

   task automatic end_test();
      check_true(resp_q.size() == 0, "response seen that no read asked for");
      check_true(exp_q.size() == 0, "read left without a response");
      if (test_errors == 0) begin
         $display("%-14s passed", test_name);
      end else begin
         $display("%-14s failed with %0d errors", test_name, test_errors);
         tests_failed++;
      end
   endtask

   `include "emesh_mem_tests.svh"

   // ##############################
   // Sequence
   // ##############################
   initial begin
      clk          = 1'b0;
      rst_n        = 1'b0;
      access_in    = 1'b0;
      packet_in    = '0;
      wait_in      = 1'b0;
      lcg_state    = LCG_SEED;
      test_name    = "reset";
      tests_run    = 0;
      tests_failed = 0;
      checks       = 0;
      errors       = 0;
      test_errors  = 0;
      repeat (RST_CYCLES) @(posedge clk);
      #DRIVE_DLY;
      rst_n = 1'b1;

      test_reset_state();
      test_write_read();
      test_lcg_burst();
      test_backpressure();
      test_interleaved();
      test_aliasing();

      $display("%0d tests, %0d failed, %0d checks, %0d errors",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule
